// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing --assert
TOP       = cache_tb
FILELIST  = vlog.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: hw/backing_mem.sv
module backing_mem #(
    parameter int MEM_LATENCY = 3,
    parameter int MEM_LINES   = 256
) (
    input logic     clock,
    input logic     reset,
    line_bus_if.mem bus
);
    import cache_pkg::*;

    localparam int CNT_W = $clog2(MEM_LATENCY + 1);
    localparam int SEL_W = $clog2(MEM_LINES);

    line_t mem_q[MEM_LINES];

    logic [CNT_W-1:0] cnt;
    logic [SEL_W-1:0] sel;
    logic             req;

    assign req = bus.req_load || bus.req_store;
    assign sel = bus.line_addr[SEL_W-1:0];
    assign bus.rline = mem_q[sel];

    // byte at address a holds a[7:0] + a[15:8]
    initial begin
        addr_t a;
        for (int l = 0; l < MEM_LINES; l++) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                a = addr_t'(l * LINE_BYTES + b);
                mem_q[l][b*8 +: 8] = a[7:0] + a[15:8];
            end
        end
    end

    // count cycles of a held request, ready goes out once
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            cnt <= '0;
            bus.ready <= 1'b0;
        end else begin
            bus.ready <= 1'b0;
            if (req && !bus.ready) begin
                if (cnt == CNT_W'(MEM_LATENCY - 1)) begin
                    cnt <= '0;
                    bus.ready <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (bus.ready && bus.req_store) begin
            mem_q[sel] <= bus.wline;
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        bus.ready |-> req);

endmodule

// File: hw/cache_ctrl.sv
module cache_ctrl #(
    parameter int ENTRIES = 8
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   enable,
    input  logic                   clear,
    input  cache_pkg::addr_t       addr,
    input  cache_pkg::word_t       wdata,
    input  cache_pkg::load_type_t  load_type,
    input  cache_pkg::store_type_t store_type,
    output cache_pkg::word_t       rdata,
    output logic                   done,
    tag_port_if.ctrl               tags,
    line_bus_if.cache              bus,
    input  cache_pkg::line_t       line_rd,
    input  cache_pkg::word_t       aligned,
    output logic                   ls_way,
    output cache_pkg::offset_t     ls_offset,
    output cache_pkg::store_type_t ls_store,
    output cache_pkg::word_t       ls_wdata,
    output logic                   ls_fill,
    output cache_pkg::line_t       fill_line
);
    import cache_pkg::*;

    localparam int INDEX_W = $clog2(ENTRIES);
    localparam int TAG_W = $bits(line_addr_t) - INDEX_W;

    ctrl_state_t state;
    line_addr_t  line_addr;
    logic        nop;
    logic        finish_now;

    // address split
    assign line_addr = addr[$bits(addr_t)-1:$bits(offset_t)];
    assign tags.index = line_addr[INDEX_W-1:0];
    assign tags.tag = line_addr[INDEX_W +: TAG_W];
    assign ls_offset = addr[$bits(offset_t)-1:0];
    assign ls_wdata = wdata;

    // an access with neither load nor store completes without a lookup
    assign nop = (load_type == NO_LOAD) && (store_type == NO_STORE);
    assign finish_now = (state == LOOKUP) && enable && (tags.hit || nop);

    // hit side updates
    assign tags.touch = finish_now && tags.hit;
    assign tags.set_dirty = tags.touch && (store_type != NO_STORE);
    assign ls_store = tags.touch ? store_type : NO_STORE;

    // miss side updates, all on the memory ready cycle
    assign tags.clean = (state == WRITEBACK) && bus.ready;
    assign tags.fill = (state == FILL) && bus.ready;
    assign ls_fill = tags.fill;
    assign fill_line = bus.rline;

    // victim way is read out during writeback and written during fill
    assign ls_way = (state == LOOKUP) ? tags.hit_way : tags.victim_way;

    assign bus.req_store = (state == WRITEBACK);
    assign bus.req_load = (state == FILL);
    assign bus.line_addr = (state == WRITEBACK) ? {tags.victim_tag, tags.index} : line_addr;
    assign bus.wline = line_rd;

    assign done = (state == FINISH);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state <= LOOKUP;
        end else begin
            case (state)
                LOOKUP: begin
                    if (finish_now) begin
                        state <= FINISH;
                    end else if (enable) begin
                        state <= tags.victim_dirty ? WRITEBACK : FILL;
                    end
                end
                WRITEBACK: begin
                    if (bus.ready) begin
                        state <= FILL;
                    end
                end
                FILL: begin
                    // back to lookup, which now hits
                    if (bus.ready) begin
                        state <= LOOKUP;
                    end
                end
                default: state <= LOOKUP;
            endcase
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            rdata <= '0;
        end else if (clear) begin
            rdata <= '0;
        end else if (finish_now) begin
            rdata <= aligned;
        end
    end

    // writeback only for a dirty victim
    assert property (@(posedge clock) disable iff (reset)
        bus.req_store |-> tags.victim_dirty);

    // a fill makes the held access hit
    assert property (@(posedge clock) disable iff (reset)
        tags.fill |=> tags.hit);

endmodule

// File: hw/cache_ifs.sv
interface line_bus_if;
    import cache_pkg::*;

    logic       req_load;
    logic       req_store;
    line_addr_t line_addr;
    line_t      wline;
    logic       ready;
    line_t      rline;

    modport cache (
        output req_load, req_store, line_addr, wline,
        input  ready, rline
    );

    modport mem (
        input  req_load, req_store, line_addr, wline,
        output ready, rline
    );
endinterface

interface tag_port_if #(
    parameter int ENTRIES = 8
);
    import cache_pkg::*;

    localparam int INDEX_W = $clog2(ENTRIES);
    localparam int TAG_W = $bits(line_addr_t) - INDEX_W;

    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag;
    logic               fill;
    logic               touch;
    logic               set_dirty;
    logic               clean;
    logic               hit;
    logic               hit_way;
    logic               victim_way;
    logic               victim_dirty;
    logic [TAG_W-1:0]   victim_tag;

    modport ctrl (
        output index, tag, fill, touch, set_dirty, clean,
        input  hit, hit_way, victim_way, victim_dirty, victim_tag
    );

    modport store (
        input  index, tag, fill, touch, set_dirty, clean,
        output hit, hit_way, victim_way, victim_dirty, victim_tag
    );
endinterface

// File: hw/cache_pkg.sv
package cache_pkg;

    typedef logic [63:0] word_t;
    typedef logic [31:0] addr_t;

    localparam int LINE_BYTES = 64;

    typedef logic [LINE_BYTES*8-1:0] line_t;
    typedef logic [$clog2(LINE_BYTES)-1:0] offset_t;

    // byte address with the line offset stripped
    typedef logic [$bits(addr_t)-$bits(offset_t)-1:0] line_addr_t;

    typedef enum logic [2:0] {
        NO_LOAD,
        LOAD_BYTE,
        LOAD_HALF,
        LOAD_WORD,
        LOAD_DWORD
    } load_type_t;

    typedef enum logic [2:0] {
        NO_STORE,
        STORE_BYTE,
        STORE_HALF,
        STORE_WORD,
        STORE_DWORD
    } store_type_t;

    typedef enum logic [1:0] {
        LOOKUP,
        WRITEBACK,
        FILL,
        FINISH
    } ctrl_state_t;

endpackage

// File: hw/cache_top.sv
module cache_top #(
    parameter int ENTRIES     = 8,
    parameter int MEM_LATENCY = 3,
    parameter int MEM_LINES   = 256
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   enable,
    input  logic                   clear,
    input  logic                   signed_type,
    input  cache_pkg::addr_t       addr,
    input  cache_pkg::word_t       wdata,
    input  cache_pkg::load_type_t  load_type,
    input  cache_pkg::store_type_t store_type,
    output cache_pkg::word_t       rdata,
    output logic                   done
);
    import cache_pkg::*;

    line_t       line_rd;
    line_t       fill_line;
    word_t       aligned;
    word_t       ls_wdata;
    offset_t     ls_offset;
    store_type_t ls_store;
    logic        ls_way;
    logic        ls_fill;

    line_bus_if bus_if ();
    tag_port_if #(.ENTRIES(ENTRIES)) tag_if ();

    cache_ctrl #(
        .ENTRIES(ENTRIES)
    ) ctrl_i (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .clear(clear),
        .addr(addr),
        .wdata(wdata),
        .load_type(load_type),
        .store_type(store_type),
        .rdata(rdata),
        .done(done),
        .tags(tag_if.ctrl),
        .bus(bus_if.cache),
        .line_rd(line_rd),
        .aligned(aligned),
        .ls_way(ls_way),
        .ls_offset(ls_offset),
        .ls_store(ls_store),
        .ls_wdata(ls_wdata),
        .ls_fill(ls_fill),
        .fill_line(fill_line)
    );

    tag_store #(
        .ENTRIES(ENTRIES)
    ) tags_i (
        .clock(clock),
        .reset(reset),
        .port(tag_if.store)
    );

    line_store #(
        .ENTRIES(ENTRIES)
    ) lines_i (
        .clock(clock),
        .index(tag_if.index),
        .way(ls_way),
        .offset(ls_offset),
        .store_type(ls_store),
        .wdata(ls_wdata),
        .fill(ls_fill),
        .fill_line(fill_line),
        .line_rd(line_rd)
    );

    load_align align_i (
        .line(line_rd),
        .offset(ls_offset),
        .load_type(load_type),
        .signed_type(signed_type),
        .word(aligned)
    );

    backing_mem #(
        .MEM_LATENCY(MEM_LATENCY),
        .MEM_LINES(MEM_LINES)
    ) mem_i (
        .clock(clock),
        .reset(reset),
        .bus(bus_if.mem)
    );

endmodule

// File: hw/line_store.sv
module line_store #(
    parameter int ENTRIES = 8
) (
    input  logic                       clock,
    input  logic [$clog2(ENTRIES)-1:0] index,
    input  logic                       way,
    input  cache_pkg::offset_t         offset,
    input  cache_pkg::store_type_t     store_type,
    input  cache_pkg::word_t           wdata,
    input  logic                       fill,
    input  cache_pkg::line_t           fill_line,
    output cache_pkg::line_t           line_rd
);
    import cache_pkg::*;

    line_t data_q[2][ENTRIES];

    logic [$bits(offset_t)+2:0] pos;

    assign pos = {offset, 3'b000};
    assign line_rd = data_q[way][index];

    always_ff @(posedge clock) begin
        if (fill) begin
            data_q[way][index] <= fill_line;
        end else begin
            // offset is aligned to the size
            case (store_type)
                STORE_BYTE:  data_q[way][index][pos +: 8] <= wdata[7:0];
                STORE_HALF:  data_q[way][index][pos +: 16] <= wdata[15:0];
                STORE_WORD:  data_q[way][index][pos +: 32] <= wdata[31:0];
                STORE_DWORD: data_q[way][index][pos +: 64] <= wdata;
                default: ;
            endcase
        end
    end

endmodule

// File: hw/load_align.sv
module load_align (
    input  cache_pkg::line_t      line,
    input  cache_pkg::offset_t    offset,
    input  cache_pkg::load_type_t load_type,
    input  logic                  signed_type,
    output cache_pkg::word_t      word
);
    import cache_pkg::*;

    logic [$bits(offset_t)+2:0] pos;

    assign pos = {offset, 3'b000};

    always_comb begin
        case (load_type)
            LOAD_BYTE: begin
                word = {{56{signed_type & line[pos+7]}}, line[pos +: 8]};
            end
            LOAD_HALF: begin
                word = {{48{signed_type & line[pos+15]}}, line[pos +: 16]};
            end
            LOAD_WORD: begin
                word = {{32{signed_type & line[pos+31]}}, line[pos +: 32]};
            end
            // full width, nothing to extend
            LOAD_DWORD: word = line[pos +: 64];
            default:    word = '0;
        endcase
    end

endmodule

// File: hw/tag_store.sv
module tag_store #(
    parameter int ENTRIES = 8
) (
    input logic       clock,
    input logic       reset,
    tag_port_if.store port
);
    import cache_pkg::*;

    localparam int INDEX_W = $clog2(ENTRIES);
    localparam int TAG_W = $bits(line_addr_t) - INDEX_W;

    logic [TAG_W-1:0] tag_q[2][ENTRIES];
    logic             valid_q[2][ENTRIES];
    logic             dirty_q[2][ENTRIES];
    logic             lru_q[ENTRIES];

    logic [1:0] way_hit;
    logic       victim;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][port.index] && (tag_q[w][port.index] == port.tag);
        end
    end

    assign port.hit = |way_hit;
    assign port.hit_way = way_hit[1];

    // lru bit names the way to replace
    assign victim = lru_q[port.index];
    assign port.victim_way = victim;
    assign port.victim_dirty = valid_q[victim][port.index] && dirty_q[victim][port.index];
    assign port.victim_tag = tag_q[victim][port.index];

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            valid_q <= '{default: '{default: 1'b0}};
            dirty_q <= '{default: '{default: 1'b0}};
            lru_q <= '{default: 1'b0};
        end else begin
            if (port.fill) begin
                valid_q[victim][port.index] <= 1'b1;
                dirty_q[victim][port.index] <= 1'b0;
            end
            if (port.clean) begin
                dirty_q[victim][port.index] <= 1'b0;
            end
            if (port.set_dirty) begin
                dirty_q[port.hit_way][port.index] <= 1'b1;
            end
            if (port.touch) begin
                lru_q[port.index] <= ~port.hit_way;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (port.fill) begin
            tag_q[victim][port.index] <= port.tag;
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        !(way_hit[0] && way_hit[1]));

endmodule

// File: test/cache_input.txt
# clear load_type store_type signed_type addr wdata expected_rdata
# types 0 none 1 byte 2 half 3 word 4 dword, addr and data in hex
0 1 0 1 00003f41 0000000000000000 ffffffffffffff80
0 1 0 0 00003f41 0000000000000000 0000000000000080
0 1 0 1 00003f40 0000000000000000 000000000000007f
0 2 0 1 00003fc0 0000000000000000 00000000000000ff
0 3 0 1 00003f84 0000000000000000 ffffffffc6c5c4c3
0 3 0 0 00003f84 0000000000000000 00000000c6c5c4c3
0 2 0 0 00003fbe 0000000000000000 000000000000fefd
0 2 0 1 00003fbe 0000000000000000 fffffffffffffefd
0 4 0 1 00002008 0000000000000000 2f2e2d2c2b2a2928
0 4 0 0 00002008 0000000000000000 2f2e2d2c2b2a2928
0 0 4 0 00002010 8877665544332211 0000000000000000
0 0 1 0 00002012 deadbeefcafe00a5 0000000000000000
0 0 2 0 00002016 123456789abcf00d 0000000000000000
0 0 3 0 0000201c ffffffff80c0e0f1 0000000000000000
0 4 0 0 00002010 0000000000000000 f00d665544a52211
0 1 0 0 00002012 0000000000000000 00000000000000a5
0 2 0 1 00002016 0000000000000000 fffffffffffff00d
0 3 0 1 00002014 0000000000000000 fffffffff00d6655
0 4 0 0 00002018 0000000000000000 80c0e0f13b3a3938
0 2 0 0 0000201e 0000000000000000 00000000000080c0
0 0 4 0 000010c8 0123456789abcdef 0000000000000000
0 4 0 0 000012c0 0000000000000000 d9d8d7d6d5d4d3d2
0 3 0 1 000014c4 0000000000000000 ffffffffdbdad9d8
0 4 0 0 000010c8 0000000000000000 0123456789abcdef
0 1 0 1 000010c7 0000000000000000 ffffffffffffffd7
1 0 0 0 00000000 0000000000000000 0000000000000000
0 1 0 0 00003f41 0000000000000000 0000000000000080

// File: test/cache_tb.sv
module cache_tb;
    import cache_pkg::*;

    localparam int MEM_LATENCY = 3;
    localparam int RESET_CYCLES = 2;
    localparam string INPUT_FILE = "test/cache_input.txt";

    logic        clock;
    logic        reset;
    logic        enable;
    logic        clear;
    logic        signed_type;
    addr_t       addr;
    word_t       wdata;
    load_type_t  load_type;
    store_type_t store_type;
    word_t       rdata;
    logic        done;

    // one entry per access line of the input file
    logic        clear_q[$];
    load_type_t  load_q[$];
    store_type_t store_q[$];
    logic        signed_q[$];
    addr_t       addr_q[$];
    word_t       wdata_q[$];
    word_t       expect_q[$];

    int cycles;
    int cycle_limit;

    cache_top dut_i (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .clear(clear),
        .signed_type(signed_type),
        .addr(addr),
        .wdata(wdata),
        .load_type(load_type),
        .store_type(store_type),
        .rdata(rdata),
        .done(done)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: no completion within %0d cycles", cycle_limit);
            $display("test failed");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            $display("test failed");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s expected %b, got %b",
                     $time, name, expected, actual);
            $display("test failed");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic read_input();
        int    fd;
        int    n;
        int    clr;
        int    ld;
        int    st;
        int    sgn;
        addr_t a;
        word_t wd;
        word_t ex;
        string text;
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            $display("could not open the input file %s", INPUT_FILE);
            $display("test failed");
            $fatal(1, "input file missing");
        end else begin
            while (!$feof(fd)) begin
                text = "";
                void'($fgets(text, fd));
                // skip comment and blank lines
                if (text.len() > 1 && text[0] != "#") begin
                    n = $sscanf(text, "%d %d %d %d %h %h %h", clr, ld, st, sgn, a, wd, ex);
                    if (n == 7) begin
                        clear_q.push_back(clr != 0);
                        load_q.push_back(load_type_t'(ld));
                        store_q.push_back(store_type_t'(st));
                        signed_q.push_back(sgn != 0);
                        addr_q.push_back(a);
                        wdata_q.push_back(wd);
                        expect_q.push_back(ex);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // starts and ends on a falling edge
    task automatic run_access(input int i);
        enable = 1'b1;
        clear = 1'b0;
        load_type = load_q[i];
        store_type = store_q[i];
        signed_type = signed_q[i];
        addr = addr_q[i];
        wdata = wdata_q[i];
        @(negedge clock);
        while (done !== 1'b1) begin
            @(negedge clock);
        end
        check_word("rdata", expect_q[i], rdata);
        enable = 1'b0;
        @(negedge clock);
        // done is a single cycle pulse
        check_flag("done", 1'b0, done);
    endtask

    task automatic clear_rdata();
        enable = 1'b0;
        clear = 1'b1;
        @(negedge clock);
        clear = 1'b0;
        check_word("rdata", word_t'(0), rdata);
    endtask

    initial begin
        cycles = 0;
        cycle_limit = 0;
        reset = 1'b1;
        enable = 1'b0;
        clear = 1'b0;
        signed_type = 1'b0;
        addr = '0;
        wdata = '0;
        load_type = NO_LOAD;
        store_type = NO_STORE;
        read_input();
        if (expect_q.size() == 0) begin
            $display("the input file holds no accesses");
            $display("test failed");
            $fatal(1, "empty input file");
        end else begin
            // worst case is a dirty miss, writeback then fill
            cycle_limit = expect_q.size() * (2 * (MEM_LATENCY + 1) + 4) + 20;
            repeat (RESET_CYCLES) @(posedge clock);
            @(negedge clock);
            reset = 1'b0;
            for (int i = 0; i < expect_q.size(); i++) begin
                if (clear_q[i]) begin
                    clear_rdata();
                end else begin
                    run_access(i);
                end
            end
            $display("test passed");
            $finish;
        end
    end

endmodule

// File: vlog.f
hw/cache_pkg.sv
hw/cache_ifs.sv
hw/load_align.sv
hw/line_store.sv
hw/tag_store.sv
hw/backing_mem.sv
hw/cache_ctrl.sv
hw/cache_top.sv
test/cache_tb.sv
